/* bench/bus_assertions.sv */
`timescale 1ns/100ps

// Protocol checks on the decoder ports
module bus_assertions (
    input logic clk_rv,
    input logic rst_rv,
    input logic mem_ready,
    input logic ram_sel,
    input logic vram_sel,
    input logic gpio_sel,
    input logic ext_valid,
    input logic ext_ready
);

    // ----------------------------------------------------------------------
    // Ready and select rules

    ready_one_cycle: assert property (@(posedge clk_rv) disable iff (!rst_rv)
        mem_ready |=> !mem_ready)
        else $error("mem_ready high for two cycles");

    // A select fires once per access, never in two cycles back to back
    one_select: assert property (@(posedge clk_rv) disable iff (!rst_rv)
        (ram_sel || vram_sel || gpio_sel) |=> !(ram_sel || vram_sel || gpio_sel))
        else $error("slave select held for more than one cycle");

    ext_valid_drops: assert property (@(posedge clk_rv) disable iff (!rst_rv)
        (ext_valid && ext_ready) |=> !ext_valid)
        else $error("ext_valid still high after ext_ready");

endmodule

bind bus_decoder bus_assertions u_bus_assertions (
    .clk_rv    (clk_rv),
    .rst_rv    (rst_rv),
    .mem_ready (mem_ready),
    .ram_sel   (ram_sel),
    .vram_sel  (vram_sel),
    .gpio_sel  (gpio_sel),
    .ext_valid (ext_valid),
    .ext_ready (ext_ready)
);

/* bench/bus_tb.sv */
`timescale 1ns/100ps
`include "soc_consts.svh"

module bus_tb import soc_pkg::*; ();

    localparam int N_ACCESSES     = 260;   // Upper bound over all tests
    localparam int ACCESS_TIMEOUT = 40;    // Cycles allowed per access
    localparam int CLK_PERIOD     = 20;

    logic                   clk_rv;
    logic                   rst_rv;
    logic                   mem_valid;
    addr_t                  mem_la_addr;
    addr_t                  mem_addr;
    word_t                  mem_wdata;
    strb_t                  mem_wstrb;
    logic                   mem_ready;
    word_t                  mem_rdata;
    logic                   bus_irq;
    logic                   ext_valid;
    logic [`EXT_ADDR_W-1:0] ext_addr;
    word_t                  ext_wdata;
    strb_t                  ext_wstrb;
    logic                   ext_ready;
    word_t                  ext_rdata;
    logic [`DELAY_W-1:0]    delay_sel_det;
    logic [`DELAY_W-1:0]    delay_sel;
    logic                   led_red;
    logic                   led_green;
    logic                   aux_rst;

    // Reference model state
    word_t       ram_model [`RAM_WORDS];
    char_t       vram_model [`VRAM_WORDS];
    word_t       ext_mem [int];
    logic        irq_model;
    logic [31:0] rng_state;
    int          errors;
    int          checks;
    int          test_err0;
    int          test_chk0;

    bus_top u_bus_top (
        .clk_rv(clk_rv), .rst_rv(rst_rv),
        .mem_valid(mem_valid), .mem_la_addr(mem_la_addr), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb), .mem_ready(mem_ready),
        .mem_rdata(mem_rdata), .bus_irq(bus_irq),
        .ext_valid(ext_valid), .ext_addr(ext_addr), .ext_wdata(ext_wdata),
        .ext_wstrb(ext_wstrb), .ext_ready(ext_ready), .ext_rdata(ext_rdata),
        .delay_sel_det(delay_sel_det), .delay_sel(delay_sel),
        .led_red(led_red), .led_green(led_green), .aux_rst(aux_rst)
    );

    initial begin
        clk_rv = 1'b0;
        forever #(CLK_PERIOD / 2) clk_rv = ~clk_rv;
    end

    // Run length follows from the number of accesses
    initial begin
        #((N_ACCESSES * 20 + 100) * CLK_PERIOD);
        $display("Watchdog expired, the tests did not finish in time");
        $display("Test failed");
        $finish;
    end

    // ----------------------------------------------------------------------
    // Helpers

    function logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic word_t merge_lanes(input word_t old, input word_t nw, input strb_t st);
        word_t r;
        r = old;
        for (int i = 0; i < 4; i++) begin
            if (st[i]) r[i*8 +: 8] = nw[i*8 +: 8];
        end
        return r;
    endfunction

    // Unwritten external words read back a pattern of the full address
    function automatic word_t ext_word(input addr_t a);
        int key;
        key = int'(a[`EXT_ADDR_W-1:2]);
        if (ext_mem.exists(key)) return ext_mem[key];
        return {a[15:0], ~a[31:16]} ^ (a << 3);
    endfunction

    function automatic logic is_unmapped(input addr_t a);
        return !(a >= `RAM_BASE || (a >= `VRAM_BASE && a < `VRAM_LIMIT) ||
                 (a >= `GPIO_BASE && a < `GPIO_LIMIT) || (a >= `EXT_BASE && a < `EXT_LIMIT));
    endfunction

    task automatic check(input string name, input word_t exp, input word_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    task automatic begin_test();
        test_err0 = errors;
        test_chk0 = checks;
    endtask

    task automatic end_test(input string name);
        $display("%-10s done, %0d checks, %0d errors", name, checks - test_chk0,
                 errors - test_err0);
    endtask

    // ----------------------------------------------------------------------
    // CPU driver with the external slave model folded in

    task automatic bus_access(input addr_t a, input strb_t st, input word_t wd,
                              output word_t rd, output int cycles);
        logic is_ext;
        logic acked;
        logic done;
        int   lat;
        is_ext = a >= `EXT_BASE && a < `EXT_LIMIT;
        lat    = 0;
        @(negedge clk_rv);
        mem_la_addr = a;                    // Look-ahead one cycle early
        @(negedge clk_rv);
        mem_valid = 1'b1;
        mem_addr  = a;
        mem_wdata = wd;
        mem_wstrb = st;
        if (is_unmapped(a)) irq_model = 1'b1;
        if (is_ext) begin
            lat = int'(next_rand() % 8);
            if (lat == 0) begin
                ext_ready = 1'b1;
                ext_rdata = ext_word(a);
            end
        end
        acked  = 1'b0;
        done   = 1'b0;
        cycles = 0;
        rd     = '0;
        while (!done) begin
            @(negedge clk_rv);
            cycles++;
            if (is_ext && !acked) begin
                check("ext_addr", word_t'(a[`EXT_ADDR_W-1:0]), word_t'(ext_addr));
                check("ext_wdata", wd, ext_wdata);
                check("ext_wstrb", word_t'(st), word_t'(ext_wstrb));
                if (ext_ready) begin        // Taken at the edge just passed
                    check("ext_valid drop", 0, word_t'(ext_valid));
                    ext_ready = 1'b0;
                    acked     = 1'b1;
                    if (st != '0) ext_mem[int'(a[`EXT_ADDR_W-1:2])] =
                        merge_lanes(ext_word(a), wd, st);
                end else begin
                    check("ext_valid", 1, word_t'(ext_valid));
                    if (cycles == lat) begin
                        ext_ready = 1'b1;
                        ext_rdata = ext_word(a);
                    end
                end
            end
            if (mem_ready) begin
                rd   = mem_rdata;
                done = 1'b1;
            end else if (cycles > ACCESS_TIMEOUT) begin
                errors++;
                $display("No mem_ready within %0d cycles for address %08h", cycles, a);
                done = 1'b1;
            end
        end
        mem_valid = 1'b0;
        mem_wstrb = '0;
        if (is_ext) check("ext latency", word_t'(lat + 1), word_t'(cycles));
        else        check("int latency", 1, word_t'(cycles));
        check("bus_irq", word_t'(irq_model), word_t'(bus_irq));
    endtask

    // ----------------------------------------------------------------------
    // Tests

    initial begin
        addr_t a;
        word_t d;
        word_t rd;
        strb_t st;
        int    cyc;
        rng_state = 32'd51;
        errors = 0;
        checks = 0;
        irq_model = 1'b0;
        rst_rv = 1'b0;
        mem_valid = 1'b0;
        mem_la_addr = '0;
        mem_addr = '0;
        mem_wdata = '0;
        mem_wstrb = '0;
        ext_ready = 1'b0;
        ext_rdata = '0;
        delay_sel_det = `DELAY_W'(next_rand());
        foreach (ram_model[i]) ram_model[i] = '0;
        foreach (vram_model[i]) vram_model[i] = '0;
        repeat (5) @(negedge clk_rv);
        rst_rv = 1'b1;

        begin_test();
        check("reset mem_ready", 0, word_t'(mem_ready));
        check("reset ext_valid", 0, word_t'(ext_valid));
        check("reset bus_irq", 0, word_t'(bus_irq));
        check("reset led_red", 0, word_t'(led_red));
        check("reset led_green", 0, word_t'(led_green));
        check("reset aux_rst", 1, word_t'(aux_rst));
        check("reset delay_sel", word_t'(delay_sel_det), word_t'(delay_sel));
        end_test("reset");

        // Upper address bits vary so the 2048-word echo is exercised
        begin_test();
        for (int i = 0; i < 80; i++) begin
            d  = next_rand();
            a  = `RAM_BASE | (next_rand() & 32'h0000_E03C);
            st = strb_t'(next_rand());
            if (i < 40) begin
                if (st == '0) st = 4'h1;
                bus_access(a, st, d, rd, cyc);
                ram_model[a[12:2]] = merge_lanes(ram_model[a[12:2]], d, st);
            end else begin
                bus_access(a, '0, d, rd, cyc);
                check("ram read", ram_model[a[12:2]], rd);
            end
        end
        end_test("ram");

        begin_test();
        for (int i = 0; i < 60; i++) begin
            d  = next_rand();
            a  = `VRAM_BASE | (next_rand() & 32'h0000_003C);
            st = i < 30 ? (strb_t'(next_rand()) | 4'h1) : 4'h0;
            bus_access(a, st, d, rd, cyc);
            if (st != '0) vram_model[a[13:2]] = d[7:0];
            else check("vram read", word_t'(vram_model[a[13:2]]), rd);
        end
        end_test("vram");

        begin_test();
        d = next_rand();
        bus_access(`GPIO_BASE + 32'h0, 4'hF, d, rd, cyc);
        check("gpio delay_sel", word_t'(d[`DELAY_W-1:0]), word_t'(delay_sel));
        bus_access(`GPIO_BASE + 32'h4, 4'hF, 32'h1, rd, cyc);
        check("gpio led_green", 1, word_t'(led_green));
        bus_access(`GPIO_BASE + 32'h8, 4'hF, 32'h1, rd, cyc);
        check("gpio led_red", 1, word_t'(led_red));
        bus_access(`GPIO_BASE + 32'hC, '0, '0, rd, cyc);
        check("gpio read aux_rst high", 1, rd);     // Still set from reset
        bus_access(`GPIO_BASE + 32'hC, 4'hF, 32'h0, rd, cyc);
        check("gpio aux_rst", 0, word_t'(aux_rst));
        bus_access(`GPIO_BASE + 32'hC, '0, '0, rd, cyc);
        check("gpio read aux_rst", 0, rd);
        bus_access(`GPIO_BASE + 32'h0, '0, '0, rd, cyc);
        check("gpio read delay", word_t'(delay_sel_det), rd);
        bus_access(`GPIO_BASE + 32'h14, '0, '0, rd, cyc);
        check("gpio read unused", 0, rd);
        end_test("gpio");

        begin_test();
        for (int i = 0; i < 60; i++) begin
            d  = next_rand();
            a  = `EXT_BASE | (next_rand() & 32'h00F0_003C);
            st = i < 30 ? strb_t'(next_rand()) : 4'h0;
            if (i < 30 && st == '0) st = 4'hF;
            bus_access(a, st, d, rd, cyc);
            if (st == '0) check("ext read", ext_word(a), rd);
        end
        end_test("external");

        begin_test();
        check("irq before error", 0, word_t'(bus_irq));
        a = 32'h0100_0000 | (next_rand() & 32'h00FF_FFFC);
        bus_access(a, '0, '0, rd, cyc);
        check("unmapped read", `UNMAPPED_DATA, rd);
        bus_access(`RAM_BASE, '0, '0, rd, cyc);
        check("ram after error", ram_model[0], rd);
        check("irq sticky", 1, word_t'(bus_irq));
        end_test("unmapped");

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* rtl/bus_decoder.sv */
`timescale 1ns/100ps
`include "soc_consts.svh"

module bus_decoder import soc_pkg::*; (
    input  logic                   clk_rv,
    input  logic                   rst_rv,

    // CPU native memory bus
    input  logic                   mem_valid,
    input  addr_t                  mem_la_addr,
    input  addr_t                  mem_addr,
    input  word_t                  mem_wdata,
    input  strb_t                  mem_wstrb,
    output logic                   mem_ready,
    output word_t                  mem_rdata,

    // External memory port
    output logic                   ext_valid,
    output logic [`EXT_ADDR_W-1:0] ext_addr,
    output word_t                  ext_wdata,
    output strb_t                  ext_wstrb,
    input  logic                   ext_ready,
    input  word_t                  ext_rdata,

    output logic                   bus_irq,

    slave_if.master                ram_bus,
    slave_if.master                vram_bus,
    slave_if.master                gpio_bus
);

    region_t region_q;
    logic    int_req;
    logic    int_ready_q;
    logic    ext_ack_q;
    word_t   ext_rdata_q;
    logic    ram_sel;
    logic    vram_sel;
    logic    gpio_sel;

    function automatic region_t classify(input addr_t a);
        region_t r;
        r = REGION_NONE;
        if (a >= `RAM_BASE)
            r = REGION_RAM;
        else if (a >= `VRAM_BASE && a < `VRAM_LIMIT)
            r = REGION_VRAM;
        else if (a >= `GPIO_BASE && a < `GPIO_LIMIT)
            r = REGION_GPIO;
        else if (a >= `EXT_BASE && a < `EXT_LIMIT)
            r = REGION_EXT;
        return r;
    endfunction

    // ----------------------------------------------------------------------
    // Region register, taken from the look-ahead address

    // Held while an access waits so that a slow external access keeps its target
    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            region_q <= REGION_NONE;
        end else if (!mem_valid || mem_ready) begin
            region_q <= classify(mem_la_addr);
        end
    end

    // ----------------------------------------------------------------------
    // Internal slaves and unmapped accesses, fixed one-cycle latency

    assign int_req = mem_valid && !mem_ready && region_q != REGION_EXT;

    assign ram_sel  = int_req && region_q == REGION_RAM;
    assign vram_sel = int_req && region_q == REGION_VRAM;
    assign gpio_sel = int_req && region_q == REGION_GPIO;

    assign ram_bus.sel    = ram_sel;
    assign ram_bus.addr   = mem_addr[31:2];
    assign ram_bus.wdata  = mem_wdata;
    assign ram_bus.wstrb  = mem_wstrb;

    assign vram_bus.sel   = vram_sel;
    assign vram_bus.addr  = mem_addr[31:2];
    assign vram_bus.wdata = char_t'(mem_wdata);  // Low byte only
    assign vram_bus.wstrb = mem_wstrb;

    assign gpio_bus.sel   = gpio_sel;
    assign gpio_bus.addr  = mem_addr[31:2];
    assign gpio_bus.wdata = mem_wdata;
    assign gpio_bus.wstrb = mem_wstrb;

    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            int_ready_q <= 1'b0;
        end else begin
            int_ready_q <= int_req;
        end
    end

    // ----------------------------------------------------------------------
    // External port handshake

    // Drops by itself once ext_ack_q turns into mem_ready
    assign ext_valid = mem_valid && !mem_ready && region_q == REGION_EXT;
    assign ext_addr  = mem_addr[`EXT_ADDR_W-1:0];
    assign ext_wdata = mem_wdata;
    assign ext_wstrb = mem_wstrb;

    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            ext_ack_q <= 1'b0;
        end else begin
            ext_ack_q <= ext_valid && ext_ready;
        end
    end

    always_ff @(posedge clk_rv) begin
        ext_rdata_q <= ext_rdata;   // Sampled alongside ready
    end

    assign mem_ready = int_ready_q || ext_ack_q;

    // ----------------------------------------------------------------------
    // Read data and bus error

    always_comb begin
        case (region_q)
            REGION_RAM:  mem_rdata = ram_bus.rdata;
            REGION_VRAM: mem_rdata = word_t'(vram_bus.rdata);
            REGION_GPIO: mem_rdata = gpio_bus.rdata;
            REGION_EXT:  mem_rdata = ext_rdata_q;
            default:     mem_rdata = `UNMAPPED_DATA;
        endcase
    end

    // Sticky until reset
    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            bus_irq <= 1'b0;
        end else if (int_req && region_q == REGION_NONE) begin
            bus_irq <= 1'b1;
        end
    end

endmodule

/* rtl/bus_ram.sv */
`timescale 1ns/100ps

// Single-port RAM on a decoder slave port, one entry per bus word
module bus_ram import soc_pkg::*; #(
    parameter type payload_t = word_t,
    parameter int  WORDS     = 1024
) (
    input  logic    clk_rv,
    slave_if.slave  bus
);

    localparam int AW    = $clog2(WORDS);
    localparam int LANES = $bits(payload_t) / 8;   // A char cell uses lane 0 only

    payload_t       mem [WORDS] = '{default: '0};
    logic [AW-1:0]  idx;

    assign idx = bus.addr[AW-1:0];      // Upper index bits ignored, contents echo

    // ----------------------------------------------------------------------
    // Write by lane, otherwise register the read word

    always_ff @(posedge clk_rv) begin
        if (bus.sel) begin
            if (bus.wstrb != '0) begin
                for (int i = 0; i < LANES; i++) begin
                    if (bus.wstrb[i]) begin
                        mem[idx][i*8 +: 8] <= bus.wdata[i*8 +: 8];
                    end
                end
            end else begin
                bus.rdata <= mem[idx];
            end
        end
    end

endmodule

/* rtl/bus_top.sv */
`timescale 1ns/100ps
`include "soc_consts.svh"

module bus_top import soc_pkg::*; (
    input  logic                   clk_rv,
    input  logic                   rst_rv,

    // CPU native memory bus
    input  logic                   mem_valid,
    input  addr_t                  mem_la_addr,
    input  addr_t                  mem_addr,
    input  word_t                  mem_wdata,
    input  strb_t                  mem_wstrb,
    output logic                   mem_ready,
    output word_t                  mem_rdata,
    output logic                   bus_irq,

    // External memory, SDRAM side
    output logic                   ext_valid,
    output logic [`EXT_ADDR_W-1:0] ext_addr,
    output word_t                  ext_wdata,
    output strb_t                  ext_wstrb,
    input  logic                   ext_ready,
    input  word_t                  ext_rdata,

    // GPIO pins
    input  logic [`DELAY_W-1:0]    delay_sel_det,
    output logic [`DELAY_W-1:0]    delay_sel,
    output logic                   led_red,
    output logic                   led_green,
    output logic                   aux_rst
);

    // ----------------------------------------------------------------------
    // Slave ports

    slave_if #(.data_t(word_t)) ram_bus ();
    slave_if #(.data_t(char_t)) vram_bus ();    // One character per word
    slave_if #(.data_t(word_t)) gpio_bus ();

    bus_decoder u_bus_decoder (
        .clk_rv      (clk_rv),
        .rst_rv      (rst_rv),
        .mem_valid   (mem_valid),
        .mem_la_addr (mem_la_addr),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_ready   (mem_ready),
        .mem_rdata   (mem_rdata),
        .ext_valid   (ext_valid),
        .ext_addr    (ext_addr),
        .ext_wdata   (ext_wdata),
        .ext_wstrb   (ext_wstrb),
        .ext_ready   (ext_ready),
        .ext_rdata   (ext_rdata),
        .bus_irq     (bus_irq),
        .ram_bus     (ram_bus.master),
        .vram_bus    (vram_bus.master),
        .gpio_bus    (gpio_bus.master)
    );

    // ----------------------------------------------------------------------
    // Memories and registers

    bus_ram #(
        .payload_t (word_t),
        .WORDS     (`RAM_WORDS)
    ) u_ram (
        .clk_rv (clk_rv),
        .bus    (ram_bus.slave)
    );

    bus_ram #(
        .payload_t (char_t),
        .WORDS     (`VRAM_WORDS)
    ) u_vram (
        .clk_rv (clk_rv),
        .bus    (vram_bus.slave)
    );

    gpio_regs u_gpio (
        .clk_rv        (clk_rv),
        .rst_rv        (rst_rv),
        .bus           (gpio_bus.slave),
        .delay_sel_det (delay_sel_det),
        .delay_sel     (delay_sel),
        .led_red       (led_red),
        .led_green     (led_green),
        .aux_rst       (aux_rst)
    );

endmodule

/* rtl/gpio_regs.sv */
`timescale 1ns/100ps
`include "soc_consts.svh"

module gpio_regs import soc_pkg::*; (
    input  logic                clk_rv,
    input  logic                rst_rv,
    slave_if.slave              bus,

    input  logic [`DELAY_W-1:0] delay_sel_det,
    output logic [`DELAY_W-1:0] delay_sel,
    output logic                led_red,
    output logic                led_green,
    output logic                aux_rst
);

    logic [3:0] offset;
    logic       wr_en;
    logic       rd_en;

    assign offset = bus.addr[3:0];      // Byte address bits 5:2
    assign wr_en  = bus.sel && bus.wstrb != '0;
    assign rd_en  = bus.sel && bus.wstrb == '0;

    // ----------------------------------------------------------------------
    // Control registers

    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            delay_sel <= delay_sel_det; // Start from the detected delay
            led_green <= 1'b0;
            led_red   <= 1'b0;
            aux_rst   <= 1'b1;          // Coprocessor held in reset
        end else if (wr_en) begin
            case (offset)
                `GPIO_DELAY:     delay_sel <= bus.wdata[`DELAY_W-1:0];
                `GPIO_LED_GREEN: led_green <= bus.wdata[0];
                `GPIO_LED_RED:   led_red   <= bus.wdata[0];
                `GPIO_AUX_RST:   aux_rst   <= bus.wdata[0];
                default: ;                  // Unused offsets ignore writes
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Status read

    always_ff @(posedge clk_rv) begin
        if (rd_en) begin
            case (offset)
                `GPIO_DELAY:   bus.rdata <= word_t'(delay_sel_det);
                `GPIO_AUX_RST: bus.rdata <= word_t'(aux_rst);
                default:       bus.rdata <= '0;
            endcase
        end
    end

endmodule

/* rtl/slave_if.sv */
`timescale 1ns/100ps

// One slave port of the bus decoder
interface slave_if #(
    parameter type data_t = logic [31:0]
) ();

    logic        sel;       // One cycle per access
    logic [29:0] addr;      // Word index, byte address bits 31:2
    data_t       wdata;
    logic [3:0]  wstrb;     // Zero means read
    data_t       rdata;     // Registered, valid the cycle after sel

    modport master (
        output sel,
        output addr,
        output wdata,
        output wstrb,
        input  rdata
    );

    modport slave (
        input  sel,
        input  addr,
        input  wdata,
        input  wstrb,
        output rdata
    );

endinterface

/* rtl/soc_consts.svh */
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// ----------------------------------------------------------------------
// Memory map

// Internal RAM, everything from the base upward
`define RAM_BASE        32'hFFFF_0000
`define RAM_WORDS       2048            // Index is address bits 12:2, contents echo

// Character video RAM, one byte kept per word
`define VRAM_BASE       32'h0800_0000
`define VRAM_LIMIT      32'h0800_4000   // First address past the region
`define VRAM_WORDS      4096

// GPIO register block
`define GPIO_BASE       32'h0300_0000
`define GPIO_LIMIT      32'h0300_0100

// External memory port
`define EXT_BASE        32'h0C00_0000
`define EXT_LIMIT       32'h0D00_0000
`define EXT_ADDR_W      24              // Byte address inside the 16 MB window

// ----------------------------------------------------------------------
// GPIO register offsets, taken from address bits 5:2

`define GPIO_DELAY      4'd0            // R: detected delay, W: delay select
`define GPIO_LED_GREEN  4'd1
`define GPIO_LED_RED    4'd2
`define GPIO_AUX_RST    4'd3            // Coprocessor reset, readable

`define DELAY_W         5

// Returned for reads that hit no region
`define UNMAPPED_DATA   32'hFFFF_FFFF

`endif

/* rtl/soc_pkg.sv */
package soc_pkg;

    // ----------------------------------------------------------------------
    // Bus payload types

    typedef logic [31:0] word_t;    // CPU data word
    typedef logic [31:0] addr_t;    // CPU byte address
    typedef logic [3:0]  strb_t;    // One bit per byte lane
    typedef logic [7:0]  char_t;    // Video RAM cell, one character

    // ----------------------------------------------------------------------
    // Decoded bus target

    typedef enum logic [2:0] {
        REGION_NONE = 3'd0,         // Nothing mapped here, raises bus_irq
        REGION_RAM  = 3'd1,
        REGION_VRAM = 3'd2,
        REGION_GPIO = 3'd3,
        REGION_EXT  = 3'd4          // SDRAM side, variable latency
    } region_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# Compile and run the bus fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module bus_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Compilation failed"
    exit 1
fi

./obj_dir/Vbus_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Test passed$" sim.log; then
    exit 0
else
    exit 1
fi

/* sources.f */
+incdir+rtl
rtl/soc_pkg.sv
rtl/slave_if.sv
rtl/bus_decoder.sv
rtl/bus_ram.sv
rtl/gpio_regs.sv
rtl/bus_top.sv
bench/bus_assertions.sv
bench/bus_tb.sv
